// ==== hdl/gecko_load_align.sv ====
// load result aligner that shifts the addressed byte or halfword down and extends it
module gecko_load_align (
    input  gecko_wb_pkg::gecko_result_t result,
    output riscv_isa_pkg::riscv_word_t value
);

    import riscv_isa_pkg::*;
    import gecko_wb_pkg::*;

    // memory word moved so the addressed byte sits at bit 0
    riscv_word_t shifted;

    // candidate fields after the shift
    logic [7:0]  load_byte;
    logic [15:0] load_half;

    // byte offset times eight
    logic [4:0]  shift_amount;

    assign shift_amount = {result.byte_offset, 3'b000};
    assign shifted      = result.value >> shift_amount;

    assign load_byte = shifted[7:0];
    assign load_half = shifted[15:0];

    // keep the loaded width, then extend
    always_comb begin
        case (result.load_kind)
            RISCV_LOAD_LB: begin
                // sign-extend from bit 7
                value = {{24{load_byte[7]}}, load_byte};
            end
            RISCV_LOAD_LH: begin
                // sign-extend from bit 15
                value = {{16{load_half[15]}}, load_half};
            end
            RISCV_LOAD_LW: begin
                // full word, offset is zero for aligned accesses
                value = shifted;
            end
            RISCV_LOAD_LBU: begin
                value = {24'b0, load_byte};
            end
            RISCV_LOAD_LHU: begin
                value = {16'b0, load_half};
            end
            RISCV_LOAD_NONE: begin
                // alu result, untouched
                value = result.value;
            end
            default: begin
                // unused encodings behave like alu results
                value = result.value;
            end
        endcase
    end

endmodule

// ==== hdl/gecko_reg_status_table.sv ====
// per-register ordering tag table that zeroes itself one entry per cycle after reset
module gecko_reg_status_table (
    input  logic clk,
    input  logic rst_n,
    input  riscv_isa_pkg::riscv_reg_addr_t [gecko_wb_pkg::GECKO_RESULT_PORTS-1:0] read_addr,
    output gecko_wb_pkg::gecko_reg_status_t [gecko_wb_pkg::GECKO_RESULT_PORTS-1:0] read_status,
    input  logic write_enable,
    input  riscv_isa_pkg::riscv_reg_addr_t write_addr,
    input  gecko_wb_pkg::gecko_reg_status_t write_status,
    output logic table_ready
);

    import riscv_isa_pkg::*;
    import gecko_wb_pkg::*;

    // one tag per architectural register
    gecko_reg_status_t status_mem [RISCV_NUM_REGS];

    // sweep control
    gecko_table_state_e state;
    gecko_table_state_e state_next;
    riscv_reg_addr_t    sweep_addr;
    riscv_reg_addr_t    sweep_addr_next;
    logic               sweep_last;

    // last entry of the sweep
    assign sweep_last = (sweep_addr == riscv_reg_addr_t'(RISCV_NUM_REGS - 1));

    // next state and sweep pointer
    always_comb begin
        state_next      = state;
        sweep_addr_next = sweep_addr;
        case (state)
            GECKO_TABLE_CLEAR: begin
                // one entry per cycle
                sweep_addr_next = sweep_addr + 1'b1;
                if (sweep_last) begin
                    state_next = GECKO_TABLE_READY;
                end
            end
            GECKO_TABLE_READY: begin
                // stays here until the next reset
                state_next = GECKO_TABLE_READY;
            end
            default: begin
                state_next = GECKO_TABLE_CLEAR;
            end
        endcase
    end

    // control state
    // held at entry 0 while rst_n is low, 32 sweep cycles after release
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state      <= GECKO_TABLE_CLEAR;
            sweep_addr <= '0;
        end else begin
            state      <= state_next;
            sweep_addr <= sweep_addr_next;
        end
    end

    assign table_ready = (state == GECKO_TABLE_READY);

    // single write port
    // sweep owns the port until the table is ready
    always_ff @(posedge clk) begin
        if (state == GECKO_TABLE_CLEAR) begin
            status_mem[sweep_addr] <= '0;
        end else if (write_enable) begin
            status_mem[write_addr] <= write_status;
        end
    end

    // asynchronous reads, one per result port
    // a write shows up on the read ports from the next cycle
    always_comb begin
        for (int k = 0; k < GECKO_RESULT_PORTS; k++) begin
            read_status[k] = status_mem[read_addr[k]];
        end
    end

endmodule

// ==== hdl/gecko_wb_pkg.sv ====
// gecko writeback package with ordering tags, stream payloads and table state
package gecko_wb_pkg;

    import riscv_isa_pkg::*;

    // number of execution unit result streams
    localparam int GECKO_RESULT_PORTS = 3;

    // width of a per-register ordering tag
    localparam int GECKO_REG_STATUS_WIDTH = 2;

    // ordering tag, wraps modulo four
    // must cover the number of results that can be in flight per register
    typedef logic [GECKO_REG_STATUS_WIDTH-1:0] gecko_reg_status_t;

    // byte position of a load inside the memory word
    typedef logic [1:0] gecko_byte_offset_t;

    // one result offered by an execution unit
    typedef struct packed {
        // destination register
        riscv_reg_addr_t    addr;
        // tag given out at issue, must match the table to pass
        gecko_reg_status_t  reg_status;
        // alu result, or the raw memory word for loads
        riscv_word_t        value;
        // none for alu results
        riscv_load_kind_e   load_kind;
        // only meaningful for byte and halfword loads
        gecko_byte_offset_t byte_offset;
    } gecko_result_t;

    // one register file write leaving the scheduler
    typedef struct packed {
        riscv_reg_addr_t addr;
        riscv_word_t     value;
    } gecko_writeback_t;

    // status table sweep state
    typedef enum logic {
        // zeroing entries after reset
        GECKO_TABLE_CLEAR = 1'b0,
        // normal operation
        GECKO_TABLE_READY = 1'b1
    } gecko_table_state_e;

endpackage

// ==== hdl/gecko_writeback.sv ====
// gecko writeback scheduler top joining the status table and the result selector
module gecko_writeback (
    input  logic clk,
    input  logic rst_n,
    input  logic [gecko_wb_pkg::GECKO_RESULT_PORTS-1:0] result_valid,
    input  gecko_wb_pkg::gecko_result_t [gecko_wb_pkg::GECKO_RESULT_PORTS-1:0] result,
    output logic [gecko_wb_pkg::GECKO_RESULT_PORTS-1:0] result_ready,
    output logic wb_valid,
    output gecko_wb_pkg::gecko_writeback_t wb,
    input  logic wb_ready
);

    import riscv_isa_pkg::*;
    import gecko_wb_pkg::*;

    // table read side, one lookup per port
    riscv_reg_addr_t   [GECKO_RESULT_PORTS-1:0] read_addr;
    gecko_reg_status_t [GECKO_RESULT_PORTS-1:0] read_status;

    // table write side, driven on acceptance
    logic              write_enable;
    riscv_reg_addr_t   write_addr;
    gecko_reg_status_t write_status;

    // high once the sweep is done
    logic              table_ready;

    // ordering tags
    gecko_reg_status_table table_i (
        .clk(clk),
        .rst_n(rst_n),
        .read_addr(read_addr),
        .read_status(read_status),
        .write_enable(write_enable),
        .write_addr(write_addr),
        .write_status(write_status),
        .table_ready(table_ready)
    );

    // arbitration, alignment and the output register
    gecko_writeback_select select_i (
        .clk(clk),
        .rst_n(rst_n),
        .result_valid(result_valid),
        .result(result),
        .result_ready(result_ready),
        .read_addr(read_addr),
        .read_status(read_status),
        .table_ready(table_ready),
        .write_enable(write_enable),
        .write_addr(write_addr),
        .write_status(write_status),
        .wb_valid(wb_valid),
        .wb(wb),
        .wb_ready(wb_ready)
    );

endmodule

// ==== hdl/gecko_writeback_select.sv ====
// writeback selector that picks the lowest eligible result port and registers its write
module gecko_writeback_select (
    input  logic clk,
    input  logic rst_n,
    input  logic [gecko_wb_pkg::GECKO_RESULT_PORTS-1:0] result_valid,
    input  gecko_wb_pkg::gecko_result_t [gecko_wb_pkg::GECKO_RESULT_PORTS-1:0] result,
    output logic [gecko_wb_pkg::GECKO_RESULT_PORTS-1:0] result_ready,
    output riscv_isa_pkg::riscv_reg_addr_t [gecko_wb_pkg::GECKO_RESULT_PORTS-1:0] read_addr,
    input  gecko_wb_pkg::gecko_reg_status_t [gecko_wb_pkg::GECKO_RESULT_PORTS-1:0] read_status,
    input  logic table_ready,
    output logic write_enable,
    output riscv_isa_pkg::riscv_reg_addr_t write_addr,
    output gecko_wb_pkg::gecko_reg_status_t write_status,
    output logic wb_valid,
    output gecko_wb_pkg::gecko_writeback_t wb,
    input  logic wb_ready
);

    import riscv_isa_pkg::*;
    import gecko_wb_pkg::*;

    logic [GECKO_RESULT_PORTS-1:0] eligible;
    logic [GECKO_RESULT_PORTS-1:0] grant;
    logic             found;
    logic             can_load;
    logic             accept;
    gecko_result_t    sel_result;
    riscv_word_t      aligned_value;
    gecko_writeback_t wb_next;

    // each port looks up the tag of its own destination register
    // a port is eligible when its tag is the one the table expects next
    always_comb begin
        for (int k = 0; k < GECKO_RESULT_PORTS; k++) begin
            read_addr[k] = result[k].addr;
            eligible[k]  = result_valid[k] && (result[k].reg_status == read_status[k]);
        end
    end

    // fixed priority, port 0 first
    always_comb begin
        grant      = '0;
        found      = 1'b0;
        sel_result = '0;
        for (int k = 0; k < GECKO_RESULT_PORTS; k++) begin
            if (eligible[k] && !found) begin
                grant[k]   = 1'b1;
                sel_result = result[k];
                found      = 1'b1;
            end
        end
    end

    // output register empty or draining this cycle
    assign can_load = !wb_valid || wb_ready;

    // nothing moves while the table is still sweeping
    assign accept = found && can_load && table_ready;

    // ready only toward the winner
    assign result_ready = grant & {GECKO_RESULT_PORTS{can_load && table_ready}};

    // bump the tag so the next result to this register can pass
    assign write_enable = accept;
    assign write_addr   = sel_result.addr;
    assign write_status = gecko_reg_status_t'(sel_result.reg_status + 1'b1);

    // load alignment on the chosen result only
    gecko_load_align align_i (
        .result(sel_result),
        .value(aligned_value)
    );

    assign wb_next = '{addr: sel_result.addr, value: aligned_value};

    // output valid
    // drops when the sink takes the write and nothing new was accepted
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wb_valid <= 1'b0;
        end else if (can_load) begin
            wb_valid <= accept;
        end
    end

    // output payload, held under back-pressure
    always_ff @(posedge clk) begin
        if (accept) begin
            wb <= wb_next;
        end
    end

endmodule

// ==== hdl/riscv_isa_pkg.sv ====
// riscv isa package with register, data word and load kind definitions
package riscv_isa_pkg;

    // rv32 word width
    localparam int RISCV_XLEN = 32;

    // x0 through x31
    localparam int RISCV_NUM_REGS = 32;

    // register number
    typedef logic [$clog2(RISCV_NUM_REGS)-1:0] riscv_reg_addr_t;

    // data word as seen by the register file
    typedef logic [RISCV_XLEN-1:0] riscv_word_t;

    // kind of result carried on a writeback stream
    // load encodings follow funct3 of the rv32i load opcode
    // funct3 3'b111 is unused by loads, so it marks a plain alu result
    typedef enum logic [2:0] {
        RISCV_LOAD_LB   = 3'b000,
        RISCV_LOAD_LH   = 3'b001,
        RISCV_LOAD_LW   = 3'b010,
        RISCV_LOAD_LBU  = 3'b100,
        RISCV_LOAD_LHU  = 3'b101,
        RISCV_LOAD_NONE = 3'b111
    } riscv_load_kind_e;

endpackage

// ==== run_sim.sh ====
#!/bin/sh
# builds the gecko writeback testbench with verilator and runs it

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir

verilator --binary --timing --assert --timescale 1ns/100ps \
    --top-module gecko_writeback_tb -Mdir "$build_dir" -f verilog.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

output=$("./$build_dir/Vgecko_writeback_tb")
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "Result: PASSED"; then
    exit 0
fi

echo "pass message not found in simulation output"
exit 1

// ==== sim/gecko_writeback_assert.sv ====
// protocol assertions for the gecko writeback scheduler result and writeback streams
module gecko_writeback_assert (
    input logic clk,
    input logic rst_n,
    input logic [gecko_wb_pkg::GECKO_RESULT_PORTS-1:0] result_valid,
    input logic [gecko_wb_pkg::GECKO_RESULT_PORTS-1:0] result_ready,
    input logic wb_valid,
    input gecko_wb_pkg::gecko_writeback_t wb,
    input logic wb_ready
);

    timeunit 1ns;
    timeprecision 100ps;

    import riscv_isa_pkg::*;

    // edges since rst_n went high, stops once the sweep is over
    int unsigned sweep_count;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            sweep_count <= 0;
        end else if (sweep_count < RISCV_NUM_REGS) begin
            sweep_count <= sweep_count + 1;
        end
    end

    // nothing moves while the table clears
    sweep_quiet_a: assert property (@(posedge clk)
        (sweep_count < RISCV_NUM_REGS) |-> (result_ready == '0 && !wb_valid))
        else $error("result_ready or wb_valid high during the status table sweep");

    // held write must not change under back-pressure
    wb_hold_a: assert property (@(posedge clk) disable iff (!rst_n)
        (wb_valid && !wb_ready) |=> (wb_valid && $stable(wb)))
        else $error("writeback dropped or changed while the sink stalled");

    // one winner per cycle
    one_ready_a: assert property (@(posedge clk) $onehot0(result_ready))
        else $error("more than one result_ready high in the same cycle");

    // ready only toward a port that offers something
    ready_valid_a: assert property (@(posedge clk) (result_ready & ~result_valid) == '0)
        else $error("result_ready high on a port without result_valid");

endmodule

// ==== sim/gecko_writeback_tb.sv ====
// testbench for the gecko writeback scheduler with a tag ordering reference model
module gecko_writeback_tb;

    timeunit 1ns;
    timeprecision 100ps;

    import riscv_isa_pkg::*;
    import gecko_wb_pkg::*;

    localparam int CLK_PERIOD    = 100;
    localparam int DRIVE_DELAY   = 10;
    localparam int RESET_CYCLES  = 16;
    localparam int SWEEP_CYCLES  = RISCV_NUM_REGS;
    localparam int STALL_CYCLES  = 6;
    localparam int ALIGN_RESULTS = 48;
    localparam int MAX_STIM      = 32;

    // cycle budget of each test
    localparam int RESET_TEST_CYCLES = RESET_CYCLES + SWEEP_CYCLES + 8;
    localparam int ORDER_TEST_CYCLES = 8;
    localparam int PRIO_TEST_CYCLES  = 8;
    localparam int STALL_TEST_CYCLES = STALL_CYCLES + 12;
    localparam int ALIGN_TEST_CYCLES = ALIGN_RESULTS + 8;
    localparam int WRAP_TEST_CYCLES  = 12;
    // sum of the budgets plus a margin
    localparam int WATCHDOG_CYCLES   = RESET_TEST_CYCLES + ORDER_TEST_CYCLES + PRIO_TEST_CYCLES
        + STALL_TEST_CYCLES + ALIGN_TEST_CYCLES + WRAP_TEST_CYCLES + 240;

    logic clk;
    logic rst_n;
    logic [GECKO_RESULT_PORTS-1:0] result_valid;
    gecko_result_t [GECKO_RESULT_PORTS-1:0] result;
    logic [GECKO_RESULT_PORTS-1:0] result_ready;
    logic wb_valid;
    gecko_writeback_t wb;
    logic wb_ready;

    // per-port stimulus lists
    // head moves on each transfer
    gecko_result_t port_list [GECKO_RESULT_PORTS][MAX_STIM];
    int port_len [GECKO_RESULT_PORTS];
    int port_head [GECKO_RESULT_PORTS];

    // tag given at issue and tag the model expects next
    gecko_reg_status_t issue_tag [RISCV_NUM_REGS];
    gecko_reg_status_t model_tag [RISCV_NUM_REGS];

    // writebacks in predicted order
    gecko_writeback_t exp_q [$];

    string test_name;
    int test_checks;
    int test_errors;
    int tests_run;
    int tests_failed;
    int total_errors;
    int accept_count;
    int unsigned lcg_state;

    gecko_writeback dut_i (
        .clk(clk),
        .rst_n(rst_n),
        .result_valid(result_valid),
        .result(result),
        .result_ready(result_ready),
        .wb_valid(wb_valid),
        .wb(wb),
        .wb_ready(wb_ready)
    );

    bind gecko_writeback gecko_writeback_assert assert_i (
        .clk(clk),
        .rst_n(rst_n),
        .result_valid(result_valid),
        .result_ready(result_ready),
        .wb_valid(wb_valid),
        .wb(wb),
        .wb_ready(wb_ready)
    );

    initial begin : clock_gen
        clk = 1'b0;
        forever begin
            #(CLK_PERIOD / 2);
            clk = ~clk;
        end
    end

    initial begin : watchdog
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("watchdog expired after %0d cycles in test %s", WATCHDOG_CYCLES, test_name);
        $display("Result: FAILED");
        $finish;
    end

    function automatic int unsigned next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic riscv_load_kind_e kind_at(int idx);
        case (idx)
            0: return RISCV_LOAD_LB;
            1: return RISCV_LOAD_LH;
            2: return RISCV_LOAD_LW;
            3: return RISCV_LOAD_LBU;
            4: return RISCV_LOAD_LHU;
            default: return RISCV_LOAD_NONE;
        endcase
    endfunction

    // register value after the load rule
    // shift down then extend
    function automatic riscv_word_t expected_value(gecko_result_t r);
        riscv_word_t word;
        int shift;
        shift = 8 * int'(r.byte_offset);
        word  = r.value >> shift;
        case (r.load_kind)
            RISCV_LOAD_LB:  word = riscv_word_t'($signed(word[7:0]));
            RISCV_LOAD_LH:  word = riscv_word_t'($signed(word[15:0]));
            RISCV_LOAD_LBU: word = riscv_word_t'(word[7:0]);
            RISCV_LOAD_LHU: word = riscv_word_t'(word[15:0]);
            RISCV_LOAD_LW:  word = word;
            default:        word = r.value;
        endcase
        return word;
    endfunction

    task automatic note_error();
        test_errors++;
        total_errors++;
    endtask

    task automatic check_int(string what, int expected, int actual);
        test_checks++;
        assert (actual == expected) else begin
            $display("CHECK FAILED test %s %s: expected %0d, actual %0d",
                test_name, what, expected, actual);
            note_error();
        end
    endtask

    task automatic check_writeback(gecko_writeback_t expected, gecko_writeback_t actual);
        test_checks++;
        assert (actual == expected) else begin
            $display("CHECK FAILED test %s: expected x%0d=%08h, actual x%0d=%08h", test_name,
                expected.addr, expected.value, actual.addr, actual.value);
            note_error();
        end
    endtask

    // queue a result on a port with the next issue tag of its register
    task automatic add_result(int port, riscv_reg_addr_t addr, riscv_word_t value,
                              riscv_load_kind_e kind, logic [1:0] offset);
        gecko_result_t r;
        r.addr        = addr;
        r.reg_status  = issue_tag[addr];
        r.value       = value;
        r.load_kind   = kind;
        r.byte_offset = offset;
        issue_tag[addr] = gecko_reg_status_t'(issue_tag[addr] + 1);
        port_list[port][port_len[port]] = r;
        port_len[port]++;
    endtask

    // lowest port whose head carries the expected tag goes next
    task automatic predict_order();
        int head [GECKO_RESULT_PORTS];
        int remaining;
        bit found;
        gecko_result_t r;
        gecko_writeback_t w;
        remaining = 0;
        for (int k = 0; k < GECKO_RESULT_PORTS; k++) begin
            head[k] = port_head[k];
            remaining += port_len[k] - port_head[k];
        end
        while (remaining > 0) begin
            found = 1'b0;
            for (int k = 0; k < GECKO_RESULT_PORTS; k++) begin
                if (!found && head[k] < port_len[k]) begin
                    r = port_list[k][head[k]];
                    if (r.reg_status == model_tag[r.addr]) begin
                        found = 1'b1;
                        head[k]++;
                        remaining--;
                        model_tag[r.addr] = gecko_reg_status_t'(model_tag[r.addr] + 1);
                        w.addr  = r.addr;
                        w.value = expected_value(r);
                        exp_q.push_back(w);
                    end
                end
            end
            if (!found) begin
                $display("test %s: stimulus can never drain, no head matches its tag", test_name);
                note_error();
                remaining = 0;
            end
        end
    endtask

    task automatic apply_inputs();
        for (int k = 0; k < GECKO_RESULT_PORTS; k++) begin
            if (port_head[k] < port_len[k]) begin
                result_valid[k] = 1'b1;
                result[k]       = port_list[k][port_head[k]];
            end else begin
                result_valid[k] = 1'b0;
                result[k]       = '0;
            end
        end
    endtask

    // mid-cycle look at what the next edge transfers
    task automatic observe();
        for (int k = 0; k < GECKO_RESULT_PORTS; k++) begin
            if (result_valid[k] && result_ready[k]) begin
                port_head[k]++;
                accept_count++;
            end
        end
        if (wb_valid && wb_ready) begin
            if (exp_q.size() == 0) begin
                $display("test %s: writeback to x%0d arrived with none expected", test_name, wb.addr);
                note_error();
            end else begin
                check_writeback(exp_q.pop_front(), wb);
            end
        end
    endtask

    task automatic step();
        @(negedge clk);
        observe();
        @(posedge clk);
        #(DRIVE_DELAY);
        apply_inputs();
    endtask

    function automatic bit stim_pending();
        for (int k = 0; k < GECKO_RESULT_PORTS; k++) begin
            if (port_head[k] < port_len[k]) begin
                return 1'b1;
            end
        end
        return 1'b0;
    endfunction

    task automatic drain();
        while (stim_pending() || exp_q.size() != 0) begin
            step();
        end
    endtask

    task automatic begin_test(string name);
        test_name   = name;
        test_checks = 0;
        test_errors = 0;
        for (int k = 0; k < GECKO_RESULT_PORTS; k++) begin
            port_len[k]  = 0;
            port_head[k] = 0;
        end
    endtask

    // idle cycles catch stray writebacks
    task automatic end_test();
        repeat (2) step();
        tests_run++;
        if (test_errors != 0) begin
            tests_failed++;
        end
        $display("test %s done: %0d checks, %0d errors", test_name, test_checks, test_errors);
    endtask

    initial begin : main_seq
        int wait_cycles;
        int start;
        int n;
        riscv_word_t word;
        rst_n        = 1'b0;
        result_valid = '0;
        result       = '0;
        wb_ready     = 1'b1;
        lcg_state    = 83;
        tests_run    = 0;
        tests_failed = 0;
        total_errors = 0;
        accept_count = 0;
        for (int r = 0; r < RISCV_NUM_REGS; r++) begin
            issue_tag[r] = '0;
            model_tag[r] = '0;
        end

        // result waits through reset and the whole sweep
        begin_test("reset_sweep");
        add_result(0, 5'd1, next_random(), RISCV_LOAD_NONE, 2'(next_random()));
        predict_order();
        @(posedge clk);
        #(DRIVE_DELAY);
        apply_inputs();
        repeat (RESET_CYCLES - 1) @(posedge clk);
        #(DRIVE_DELAY);
        rst_n = 1'b1;
        wait_cycles = 0;
        @(negedge clk);
        while (!result_ready[0]) begin
            wait_cycles++;
            @(negedge clk);
        end
        observe();
        @(posedge clk);
        #(DRIVE_DELAY);
        apply_inputs();
        drain();
        check_int("refused edges", SWEEP_CYCLES, wait_cycles);
        end_test();

        // tag 1 on port 0 must wait for tag 0 on port 2
        begin_test("ordering");
        add_result(2, 5'd5, next_random(), RISCV_LOAD_NONE, 2'(next_random()));
        add_result(0, 5'd5, next_random(), RISCV_LOAD_NONE, 2'(next_random()));
        predict_order();
        apply_inputs();
        drain();
        end_test();

        begin_test("priority");
        for (int k = 0; k < GECKO_RESULT_PORTS; k++) begin
            add_result(k, riscv_reg_addr_t'(6 + k), next_random(), RISCV_LOAD_NONE,
                2'(next_random()));
        end
        predict_order();
        apply_inputs();
        start = accept_count;
        repeat (GECKO_RESULT_PORTS) step();
        check_int("accepts on consecutive edges", GECKO_RESULT_PORTS, accept_count - start);
        drain();
        end_test();

        // sink stalls while the first result fills the output register
        begin_test("backpressure");
        wb_ready = 1'b0;
        add_result(0, 5'd9, next_random(), RISCV_LOAD_NONE, 2'(next_random()));
        add_result(1, 5'd10, next_random(), RISCV_LOAD_NONE, 2'(next_random()));
        add_result(2, 5'd11, next_random(), RISCV_LOAD_NONE, 2'(next_random()));
        add_result(0, 5'd12, next_random(), RISCV_LOAD_NONE, 2'(next_random()));
        predict_order();
        apply_inputs();
        step();
        start = accept_count;
        // held write is the first one the model predicts
        repeat (STALL_CYCLES) begin
            step();
            check_writeback(exp_q[0], wb);
        end
        check_int("accepts while stalled", 0, accept_count - start);
        wb_ready = 1'b1;
        drain();
        end_test();

        // every kind and offset
        // bytes forced negative then positive
        begin_test("load_align");
        n = 0;
        for (int k = 0; k < 6; k++) begin
            for (int off = 0; off < 4; off++) begin
                for (int s = 0; s < 2; s++) begin
                    word = next_random();
                    word = (s == 0) ? (word | 32'h8080_8080) : (word & 32'h7f7f_7f7f);
                    add_result(n % GECKO_RESULT_PORTS, riscv_reg_addr_t'(1 + n % 30), word,
                        kind_at(k), 2'(off));
                    n++;
                end
            end
        end
        predict_order();
        apply_inputs();
        drain();
        end_test();

        // x31 is untouched so far
        // tags run 0 1 2 3 0
        begin_test("tag_wrap");
        add_result(2, 5'd31, next_random(), RISCV_LOAD_NONE, 2'(next_random()));
        add_result(1, 5'd31, next_random(), RISCV_LOAD_NONE, 2'(next_random()));
        add_result(0, 5'd31, next_random(), RISCV_LOAD_NONE, 2'(next_random()));
        add_result(2, 5'd31, next_random(), RISCV_LOAD_NONE, 2'(next_random()));
        add_result(1, 5'd31, next_random(), RISCV_LOAD_NONE, 2'(next_random()));
        predict_order();
        apply_inputs();
        drain();
        end_test();

        $display("summary: %0d tests, %0d failed, %0d errors", tests_run, tests_failed,
            total_errors);
        if (total_errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

// ==== verilog.f ====
hdl/riscv_isa_pkg.sv
hdl/gecko_wb_pkg.sv
hdl/gecko_reg_status_table.sv
hdl/gecko_load_align.sv
hdl/gecko_writeback_select.sv
hdl/gecko_writeback.sv
sim/gecko_writeback_assert.sv
sim/gecko_writeback_tb.sv
